//--- src.f
src/knight_pkg.sv
src/move_store.sv
src/tour_cmd.sv
src/cmd_exec.sv
src/knight_top.sv
verif/tb_knight.sv

//--- run.sh
#!/bin/sh
# Build and run the knight tour simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module tb_knight -Mdir obj_dir -o sim_knight

./obj_dir/sim_knight > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

//--- verif/tb_knight.sv
// Knight tour testbench
`timescale 1ns/1ps

module tb_knight import knight_pkg::*; ();

  localparam int HOST_N   = 12;                                   // Host commands in phase one.
  localparam int HOST_CYC = HOST_N * (6 * STEP_CYCLES + 6);       // At most 6 squares each.
  localparam int TOUR_CYC = TOUR_LEN * (3 * STEP_CYCLES + 6);     // 3 squares per L-shape.
  localparam int LIMIT_NS = 2 * (40 + HOST_CYC + 2 * TOUR_CYC) * 40;

  logic   clk, rst_n, start_tour, host_rdy, host_clr, load_en;
  logic   resp_vld, fanfare, off_board, busy;
  cmd_t   host_cmd;
  idx_t   load_addr;
  move_t  load_move;
  resp_t  resp;
  coord_t pos_x, pos_y;

  cmd_t    exp_cmd [128];         // Commands the executor must take in order.
  resp_t   exp_resp [128];        // Response owed for each of them.
  int      wr, rd, cyc, due;      // Queue pointers, cycle count, completion cycle.
  int      resp_cnt, fan_cnt;     // Pulses within the current tour.
  logic    active, m_busy, m_off;
  coord_t  m_x, m_y;              // Position once the current command ends.
  cmd_t    cur_cmd;
  resp_t   cur_resp;
  move_t   tour_moves [TOUR_LEN];
  logic [31:0] rng;

  knight_top dut (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;          // 40 ns period.

  //////////////////////////////////////////////////
  // Failure reporting.
  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("** Error: %s expected %0h actual %0h", name, exp, act);
    $display("test failed");
    $fatal(1, "mismatch in %s", name);
  endtask

  task automatic abort_with(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "%s", what);
  endtask

  //////////////////////////////////////////////////
  // Reference model.
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // One leg of an L-shape. Bits 0,1,4,5 have the long leg vertical.
  function automatic cmd_t leg_cmd(input move_t m, input bit horz);
    int         k;
    logic [3:0] vn, hn;
    heading_e   vh, hh;
    k = 0;
    for (int i = 0; i < 8; i++) begin
      if (m[i])
        k = i;
    end
    vn = (k == 0 || k == 1 || k == 4 || k == 5) ? 4'd2 : 4'd1;
    hn = 4'd3 - vn;
    vh = (k >= 3 && k <= 6) ? SOUTH : NORTH;     // Bits 3 to 6 go south.
    hh = (k >= 1 && k <= 4) ? WEST : EAST;       // Bits 1 to 4 go west.
    return horz ? {OP_FANFARE, hh, hn} : {OP_MOVE, vh, vn};
  endfunction

  function automatic int exec_cycles(input cmd_t c);
    if ((c[15:12] == OP_MOVE || c[15:12] == OP_FANFARE) && c[3:0] != 4'd0)
      return STEP_CYCLES * c[3:0];
    return 1;                                    // No-op completes right away.
  endfunction

  // Steps square by square. A step past the edge is dropped and flagged.
  function automatic logic [6:0] walk(input coord_t x, input coord_t y, input logic off,
                                      input cmd_t c);
    if (c[15:12] == OP_MOVE || c[15:12] == OP_FANFARE) begin
      for (int i = 0; i < c[3:0]; i++) begin
        case (c[11:4])
          NORTH: if (y == BOARD_DIM - 1) off = 1'b1;
                 else y = y + 1'b1;
          SOUTH: if (y == 0) off = 1'b1;
                 else y = y - 1'b1;
          EAST:  if (x == BOARD_DIM - 1) off = 1'b1;
                 else x = x + 1'b1;
          WEST:  if (x == 0) off = 1'b1;
                 else x = x - 1'b1;
          default: ;
        endcase
      end
    end
    return {off, y, x};
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd       <= 0;
      cyc      <= 0;
      due      <= 0;
      active   <= 1'b0;
      cur_cmd  <= '0;
      cur_resp <= RESP_BUSY;
      m_x      <= START_X;
      m_y      <= START_Y;
      m_off    <= 1'b0;
      m_busy   <= 1'b0;
      resp_cnt <= 0;
      fan_cnt  <= 0;
    end else begin
      cyc <= cyc + 1;
      if (host_clr) begin                        // Executor takes the head of the queue.
        cur_cmd  <= exp_cmd[rd];
        cur_resp <= exp_resp[rd];
        rd       <= rd + 1;
        due      <= cyc + exec_cycles(exp_cmd[rd]);
        {m_off, m_y, m_x} <= walk(m_x, m_y, m_off, exp_cmd[rd]);
        active   <= 1'b1;
      end
      if (resp_vld) begin
        active   <= 1'b0;
        resp_cnt <= resp_cnt + 1;
        if (fanfare) fan_cnt <= fan_cnt + 1;
        if (cur_resp == RESP_DONE) m_busy <= 1'b0; // Last leg hands back to host.
      end
      if (start_tour && !m_busy) begin
        m_busy   <= 1'b1;
        resp_cnt <= 0;
        fan_cnt  <= 0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks sampled mid-cycle.
  a_accept_owed : assert property (@(negedge clk) disable iff (!rst_n)
    host_clr |-> (rd != wr)) else abort_with("executor took a command nobody offered");
  a_accept_cmd : assert property (@(negedge clk) disable iff (!rst_n)
    host_clr |-> (dut.cmd == exp_cmd[rd]))
    else report_mismatch("accept_cmd", exp_cmd[rd], dut.cmd);
  a_clr_once : assert property (@(negedge clk) disable iff (!rst_n)
    host_clr |=> !host_clr) else abort_with("host_clr stayed high for two cycles");
  a_resp_active : assert property (@(negedge clk) disable iff (!rst_n)
    resp_vld |-> active) else abort_with("completion with no command in flight");
  a_step_timing : assert property (@(negedge clk) disable iff (!rst_n)
    resp_vld |-> (cyc == due)) else report_mismatch("step_timing", due, cyc);
  a_resp_byte : assert property (@(negedge clk) disable iff (!rst_n)
    resp_vld |-> (resp == cur_resp)) else report_mismatch("resp_byte", cur_resp, resp);
  a_pos_x : assert property (@(negedge clk) disable iff (!rst_n)
    resp_vld |-> (pos_x == m_x)) else report_mismatch("pos_x", m_x, pos_x);
  a_pos_y : assert property (@(negedge clk) disable iff (!rst_n)
    resp_vld |-> (pos_y == m_y)) else report_mismatch("pos_y", m_y, pos_y);
  a_off_board : assert property (@(negedge clk) disable iff (!rst_n)
    resp_vld |-> (off_board == m_off)) else report_mismatch("off_board", m_off, off_board);
  a_fanfare : assert property (@(negedge clk) disable iff (!rst_n)
    fanfare == (resp_vld && cur_cmd[15:12] == OP_FANFARE))
    else report_mismatch("fanfare", resp_vld && cur_cmd[15:12] == OP_FANFARE, fanfare);
  a_busy : assert property (@(negedge clk) disable iff (!rst_n)
    busy == m_busy) else report_mismatch("busy", m_busy, busy);
  a_tour_resps : assert property (@(negedge clk) disable iff (!rst_n)
    $fell(busy) |-> (resp_cnt == 2 * TOUR_LEN))
    else report_mismatch("tour_resp_count", 2 * TOUR_LEN, resp_cnt);
  a_tour_fanfares : assert property (@(negedge clk) disable iff (!rst_n)
    $fell(busy) |-> (fan_cnt == TOUR_LEN))
    else report_mismatch("tour_fanfares", TOUR_LEN, fan_cnt);

  //////////////////////////////////////////////////
  // Stimulus.
  function automatic heading_e pick_heading(input logic [1:0] sel);
    case (sel)
      2'd0:    return NORTH;
      2'd1:    return WEST;
      2'd2:    return SOUTH;
      default: return EAST;
    endcase
  endfunction

  // Mostly moves with some fanfares and no-ops. Counts run 1 to 6.
  function automatic cmd_t host_word(input logic [31:0] r);
    logic [3:0] op;
    logic [3:0] sq;
    op = OP_MOVE;
    if (r[1:0] == 2'd1) op = OP_FANFARE;
    else if (r[1:0] == 2'd2) op = (r[7:4] == 4'h4 || r[7:4] == 4'h5) ? 4'h9 : r[7:4];
    sq = 4'd1 + 4'(r[18:16] % 3'd6);
    return {op, pick_heading(r[9:8]), sq};
  endfunction

  task automatic send_host(input cmd_t c);
    int n;
    exp_cmd[wr]  = c;
    exp_resp[wr] = RESP_BUSY;                    // Idle sequencer never says done.
    wr = wr + 1;
    host_cmd = c;
    host_rdy = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 50) abort_with("host command was never accepted");
    end while (!host_clr);
    host_rdy = 1'b0;                             // Host drops ready on the clear.
    n = 0;
    while (!resp_vld) begin
      @(negedge clk);
      n++;
      if (n > 100) abort_with("host command never completed");
    end
  endtask

  task automatic run_tour(input bit hold);
    int n;
    for (int i = 0; i < TOUR_LEN; i++) begin
      exp_cmd[wr]      = leg_cmd(tour_moves[i], 1'b0);
      exp_resp[wr]     = RESP_BUSY;
      exp_cmd[wr + 1]  = leg_cmd(tour_moves[i], 1'b1);
      exp_resp[wr + 1] = (i == TOUR_LEN - 1) ? RESP_DONE : RESP_BUSY;
      wr = wr + 2;
    end
    start_tour = 1'b1;
    @(negedge clk);
    start_tour = 1'b0;
    if (hold) begin                              // Host tries to cut in.
      host_cmd = {OP_MOVE, NORTH, 4'd1};
      host_rdy = 1'b1;
    end
    n = 0;
    while (busy) begin
      @(negedge clk);
      n++;
      if (n > 2 * TOUR_CYC) abort_with("tour did not finish");
    end
    host_rdy = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    rst_n      = 1'b0;
    start_tour = 1'b0;
    host_rdy   = 1'b0;
    host_cmd   = '0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_move  = '0;
    rng = 32'd26554;
    wr = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (pos_x !== START_X) report_mismatch("reset_pos_x", START_X, pos_x);
    if (pos_y !== START_Y) report_mismatch("reset_pos_y", START_Y, pos_y);
    if ({host_clr, resp_vld, fanfare, off_board, busy, dut.cmd_rdy} !== 6'b0)
      abort_with("control outputs not low after reset");
    for (int i = 0; i < TOUR_LEN; i++) begin     // Random one-hot tour.
      rng = xorshift(rng);
      tour_moves[i] = 8'd1 << rng[2:0];
      load_en   = 1'b1;
      load_addr = idx_t'(i);
      load_move = tour_moves[i];
      @(negedge clk);
    end
    load_en = 1'b0;
    @(negedge clk);
    send_host({OP_MOVE, NORTH, 4'd6});           // Runs into the top edge.
    send_host({4'hF, WEST, 4'd3});               // No-op.
    for (int i = 0; i < HOST_N - 2; i++) begin
      rng = xorshift(rng);
      send_host(host_word(rng));
    end
    @(negedge clk);
    run_tour(1'b0);
    run_tour(1'b1);                              // Replay with host locked out.
    repeat (4) @(negedge clk);
    if (rd != wr) begin
      $display("%0d expected commands were never executed", wr - rd);
      $display("test failed");
      $fatal(1, "commands left over");
    end else begin
      $display("test passed");
      $finish;
    end
  end

  initial begin
    #(LIMIT_NS);
    $display("watchdog expired after %0d ns, the DUT stopped making progress", LIMIT_NS);
    $display("test failed");
    $fatal(1, "timeout");
  end

endmodule

//--- src/knight_top.sv
// Knight tour replay top level
`timescale 1ns/1ps

module knight_top import knight_pkg::*; (
  input  logic   clk,         // System clock.
  input  logic   rst_n,       // Async reset, active low.
  input  logic   start_tour,  // Replay the stored tour.
  input  cmd_t   host_cmd,    // Host command.
  input  logic   host_rdy,    // Host command valid.
  output logic   host_clr,    // Host command taken.
  input  logic   load_en,     // Store write strobe.
  input  idx_t   load_addr,   // Store write index.
  input  move_t  load_move,   // Store write data.
  output resp_t  resp,        // Response byte.
  output logic   resp_vld,    // Response valid, one cycle.
  output coord_t pos_x,       // Knight column.
  output coord_t pos_y,       // Knight row.
  output logic   fanfare,     // Fanfare command finished.
  output logic   off_board,   // Sticky edge hit.
  output logic   busy         // Tour in progress.
);

  idx_t  mv_indx;   // Sequencer to store.
  move_t move;      // Store to sequencer.
  cmd_t  cmd;       // Muxed command channel.
  logic  cmd_rdy;

  move_store u_store (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_move (load_move),
    .mv_indx   (mv_indx),
    .move      (move)
  );

  // Producer. Also the host/tour mux.
  tour_cmd u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_tour  (start_tour),
    .move        (move),
    .mv_indx     (mv_indx),
    .host_cmd    (host_cmd),
    .host_rdy    (host_rdy),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .clr_cmd_rdy (host_clr),   // Same pulse clears the host.
    .send_resp   (resp_vld),
    .resp        (resp),
    .busy        (busy)
  );

  // Consumer.
  cmd_exec u_exec (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .clr_cmd_rdy (host_clr),
    .send_resp   (resp_vld),
    .pos_x       (pos_x),
    .pos_y       (pos_y),
    .fanfare     (fanfare),
    .off_board   (off_board)
  );

endmodule

//--- src/cmd_exec.sv
// Knight command executor
`timescale 1ns/1ps

module cmd_exec import knight_pkg::*; (
  input  logic   clk,          // System clock.
  input  logic   rst_n,        // Async reset, active low.
  input  cmd_t   cmd,          // Offered command.
  input  logic   cmd_rdy,      // Command on offer.
  output logic   clr_cmd_rdy,  // Command taken, one cycle.
  output logic   send_resp,    // Command finished, one cycle.
  output coord_t pos_x,        // Knight column.
  output coord_t pos_y,        // Knight row.
  output logic   fanfare,      // Fanfare command finished.
  output logic   off_board     // Sticky, a step hit the edge.
);

  typedef enum logic [1:0] {WAIT, ACCEPT, STEP, DONE} exec_state_e;

  exec_state_e state;
  exec_state_e nxt_state;

  cmd_t       cmd_q;      // Command being executed.
  logic [3:0] sq_left;    // Squares still to go.
  logic [3:0] cyc_cnt;    // Clock within the current square.
  logic       sq_end;     // Last clock of a square.
  logic       runs;       // Offered command actually moves.
  logic       step_ok;    // Next square is on the board.
  heading_e   hdg;
  coord_t     nxt_x;
  coord_t     nxt_y;

  // Only a move or fanfare with a nonzero count spends time stepping.
  assign runs = ((cmd[15:12] == OP_MOVE) || (cmd[15:12] == OP_FANFARE)) &&
                (cmd[3:0] != 4'd0);

  assign sq_end = (cyc_cnt == 4'(STEP_CYCLES - 1));
  assign hdg    = heading_e'(cmd_q[11:4]);

  //////////////////////////////////////////////////
  // Control FSM.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= WAIT;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    case (state)
      WAIT:   if (cmd_rdy) nxt_state = ACCEPT;
      ACCEPT: nxt_state = runs ? STEP : DONE;   // No-op finishes next cycle.
      STEP:   if (sq_end && (sq_left == 4'd1)) nxt_state = DONE;
      default: nxt_state = WAIT;                // DONE.
    endcase
  end

  assign clr_cmd_rdy = (state == ACCEPT);
  assign send_resp   = (state == DONE);
  assign fanfare     = send_resp && (cmd_q[15:12] == OP_FANFARE);

  //////////////////////////////////////////////////
  // Command register and counters.
  always_ff @(posedge clk) begin
    if (state == ACCEPT)
      cmd_q <= cmd;        // Latched with the clr pulse.
  end

  // The accept cycle counts as the first clock of the first square,
  // so the last square ends STEP_CYCLES*n - 1 cycles after accept.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      sq_left <= '0;
      cyc_cnt <= '0;
    end else if (state == ACCEPT) begin
      sq_left <= cmd[3:0];
      cyc_cnt <= 4'd1;
    end else if (state == STEP) begin
      if (sq_end) begin
        sq_left <= sq_left - 1'b1;
        cyc_cnt <= '0;
      end else begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Position with edge guard.
  // Unknown headings keep the knight where it is.
  always_comb begin
    step_ok = 1'b1;
    nxt_x   = pos_x;
    nxt_y   = pos_y;
    case (hdg)
      NORTH: if (pos_y == coord_t'(BOARD_DIM - 1)) step_ok = 1'b0;
             else nxt_y = pos_y + 1'b1;
      SOUTH: if (pos_y == '0) step_ok = 1'b0;
             else nxt_y = pos_y - 1'b1;
      EAST:  if (pos_x == coord_t'(BOARD_DIM - 1)) step_ok = 1'b0;
             else nxt_x = pos_x + 1'b1;
      WEST:  if (pos_x == '0) step_ok = 1'b0;
             else nxt_x = pos_x - 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pos_x     <= START_X;
      pos_y     <= START_Y;
      off_board <= 1'b0;
    end else if ((state == STEP) && sq_end) begin
      if (step_ok) begin
        pos_x <= nxt_x;   // Square done.
        pos_y <= nxt_y;
      end else begin
        off_board <= 1'b1; // Blocked step still takes its time.
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks.
  a_pulse_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(clr_cmd_rdy && send_resp))
    else $error("cmd_exec: clr_cmd_rdy and send_resp together");

  a_clr_single : assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy |=> !clr_cmd_rdy)
    else $error("cmd_exec: clr_cmd_rdy longer than one cycle");

  a_resp_single : assert property (@(posedge clk) disable iff (!rst_n)
    send_resp |=> !send_resp)
    else $error("cmd_exec: send_resp longer than one cycle");

endmodule

//--- src/tour_cmd.sv
// Knight tour sequencer
`timescale 1ns/1ps

module tour_cmd import knight_pkg::*; (
  input  logic  clk,          // System clock.
  input  logic  rst_n,        // Async reset, active low.
  input  logic  start_tour,   // Replay the store from index 0.
  input  move_t move,         // One-hot move at mv_indx.
  output idx_t  mv_indx,      // Move being played.
  input  cmd_t  host_cmd,     // Command from the serial host.
  input  logic  host_rdy,     // Host command valid.
  output cmd_t  cmd,          // Muxed command to the executor.
  output logic  cmd_rdy,      // Muxed ready to the executor.
  input  logic  clr_cmd_rdy,  // Executor took the command.
  input  logic  send_resp,    // Executor finished a command.
  output resp_t resp,         // Response byte, valid with send_resp.
  output logic  busy          // Tour in progress.
);

  tour_state_e state;
  tour_state_e nxt_state;

  logic       tour_done;    // Playing the last move.
  logic       clr_index;    // Restart at move 0.
  logic       inc_index;    // Advance to the next move.
  logic       tour_ctrl;    // Sequencer owns the command channel.
  logic       tour_rdy;     // Sequencer command on offer.
  logic       cap_horz;     // Horizontal half selected.

  heading_e   vert_hdg;
  heading_e   horz_hdg;
  heading_e   heading;
  logic [3:0] vert_cnt;
  logic [3:0] horz_cnt;
  logic [3:0] square_cnt;
  opcode_e    opcode;
  cmd_t       seq_cmd;      // Command formed from the current move.

  //////////////////////////////////////////////////
  // Move counter.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      mv_indx <= '0;
    else if (clr_index)
      mv_indx <= '0;                 // New tour.
    else if (inc_index)
      mv_indx <= mv_indx + 1'b1;     // Next L-shape.
  end

  assign tour_done = (mv_indx == idx_t'(TOUR_LEN - 1));

  //////////////////////////////////////////////////
  // Move decoder.
  // Splits the one-hot L-shape into its vertical and horizontal legs.
  always_comb begin
    vert_hdg = NORTH;   // Zero squares if move is not one-hot.
    vert_cnt = 4'd0;
    horz_hdg = EAST;
    horz_cnt = 4'd0;
    case (1'b1)
      move[0]: begin    // 2 north, 1 east.
        vert_cnt = 4'd2;
        horz_cnt = 4'd1;
      end
      move[1]: begin    // 2 north, 1 west.
        vert_cnt = 4'd2;
        horz_hdg = WEST;
        horz_cnt = 4'd1;
      end
      move[2]: begin    // 1 north, 2 west.
        vert_cnt = 4'd1;
        horz_hdg = WEST;
        horz_cnt = 4'd2;
      end
      move[3]: begin    // 1 south, 2 west.
        vert_hdg = SOUTH;
        vert_cnt = 4'd1;
        horz_hdg = WEST;
        horz_cnt = 4'd2;
      end
      move[4]: begin    // 2 south, 1 west.
        vert_hdg = SOUTH;
        vert_cnt = 4'd2;
        horz_hdg = WEST;
        horz_cnt = 4'd1;
      end
      move[5]: begin    // 2 south, 1 east.
        vert_hdg = SOUTH;
        vert_cnt = 4'd2;
        horz_cnt = 4'd1;
      end
      move[6]: begin    // 1 south, 2 east.
        vert_hdg = SOUTH;
        vert_cnt = 4'd1;
        horz_cnt = 4'd2;
      end
      move[7]: begin    // 1 north, 2 east.
        vert_cnt = 4'd1;
        horz_cnt = 4'd2;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Command, response and channel mux.
  assign cap_horz   = (state == HORZ) || (state == HOLDH);
  assign heading    = cap_horz ? horz_hdg : vert_hdg;
  assign square_cnt = cap_horz ? horz_cnt : vert_cnt;
  assign opcode     = cap_horz ? OP_FANFARE : OP_MOVE;  // Fanfare closes the L.
  assign seq_cmd    = {opcode, heading, square_cnt};

  // Done only on the horizontal leg of the last move.
  assign resp = (tour_done && (state == HOLDH)) ? RESP_DONE : RESP_BUSY;

  assign cmd     = tour_ctrl ? seq_cmd  : host_cmd;
  assign cmd_rdy = tour_ctrl ? tour_rdy : host_rdy;
  assign busy    = tour_ctrl;

  //////////////////////////////////////////////////
  // Sequencer FSM.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    tour_ctrl = 1'b1;
    tour_rdy  = 1'b0;
    clr_index = 1'b0;
    inc_index = 1'b0;
    case (state)
      VERT: begin
        tour_rdy = 1'b1;            // Offer vertical leg.
        if (clr_cmd_rdy)
          nxt_state = HOLDV;
      end
      HOLDV: begin
        if (send_resp)
          nxt_state = HORZ;         // Vertical leg done.
      end
      HORZ: begin
        tour_rdy = 1'b1;            // Offer horizontal leg.
        if (clr_cmd_rdy)
          nxt_state = HOLDH;
      end
      HOLDH: begin
        if (send_resp) begin
          if (tour_done) begin
            nxt_state = IDLE;       // Tour complete, hand back to host.
          end else begin
            inc_index = 1'b1;
            nxt_state = VERT;
          end
        end
      end
      default: begin              // IDLE, host passes through.
        tour_ctrl = 1'b0;
        if (start_tour) begin
          clr_index = 1'b1;
          nxt_state = VERT;
        end
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Checks.
  // Offered tour command holds until the executor latches it.
  a_cmd_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (busy && cmd_rdy && !clr_cmd_rdy) |=> $stable(cmd))
    else $error("tour_cmd: command changed while offered");

  // Every move played from the store is a legal L-shape.
  a_move_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> $onehot(move))
    else $error("tour_cmd: move %0d is %b, not one-hot", mv_indx, move);

endmodule

//--- src/move_store.sv
// Knight tour move store
`timescale 1ns/1ps

module move_store import knight_pkg::*; (
  input  logic  clk,        // System clock.
  input  logic  rst_n,      // Async reset, active low.
  input  logic  load_en,    // Write strobe from the loader.
  input  idx_t  load_addr,  // Entry to write.
  input  move_t load_move,  // One-hot move to store.
  input  idx_t  mv_indx,    // Read index from the sequencer.
  output move_t move        // Move at mv_indx, no read latency.
);

  //////////////////////////////////////////////////
  // Move table.
  move_t tbl [TOUR_LEN];    // One entry per move of the tour.

  // Table clears to all zero, so an unloaded tour shows up as a
  // non one-hot move at the sequencer.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < TOUR_LEN; i++) begin
        tbl[i] <= '0;
      end
    end else if (load_en && (load_addr < TOUR_LEN)) begin
      tbl[load_addr] <= load_move;  // Write lands on this edge.
    end
  end

  // Asynchronous read. Indices past the tour read as no move.
  assign move = (mv_indx < TOUR_LEN) ? tbl[mv_indx] : '0;

  //////////////////////////////////////////////////
  // Checks.
  // Loader only writes legal L-shapes into real entries.
  a_load_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    load_en |-> ($onehot(load_move) && (load_addr < TOUR_LEN)))
    else $error("move_store: bad load, addr %0d move %b", load_addr, load_move);

endmodule

//--- src/knight_pkg.sv
// Knight tour shared definitions
package knight_pkg;

  //////////////////////////////////////////////////
  // Widths that carry a meaning.
  typedef logic [2:0]  coord_t;   // Board coordinate, 0 to BOARD_DIM-1.
  typedef logic [4:0]  idx_t;     // Move index into the tour store.
  typedef logic [7:0]  move_t;    // One-hot L-shape, bit 0 is 2N then 1E.
  typedef logic [15:0] cmd_t;     // {opcode[15:12], heading[11:4], squares[3:0]}.
  typedef logic [7:0]  resp_t;    // Response byte back to the host.

  //////////////////////////////////////////////////
  // Board, tour and timing.
  localparam int     TOUR_LEN    = 24;    // Moves in one tour.
  localparam int     BOARD_DIM   = 5;     // 5x5 board.
  localparam int     STEP_CYCLES = 4;     // Clocks spent on each square.
  localparam coord_t START_X     = 3'd2;  // Centre square after reset.
  localparam coord_t START_Y     = 3'd2;

  localparam resp_t  RESP_DONE   = 8'hA5; // Last half of the last move.
  localparam resp_t  RESP_BUSY   = 8'h5A; // Any other completion.

  //////////////////////////////////////////////////
  // Command fields.
  typedef enum logic [3:0] {
    OP_MOVE    = 4'b0100,  // Plain move.
    OP_FANFARE = 4'b0101   // Move, then fanfare at the end.
  } opcode_e;              // Anything else completes as a no-op.

  typedef enum logic [7:0] {
    NORTH = 8'h00,
    WEST  = 8'h3F,
    SOUTH = 8'h7F,
    EAST  = 8'hBF
  } heading_e;

  // Sequencer phases, two commands per move.
  typedef enum logic [2:0] {
    IDLE,   // Host owns the command channel.
    VERT,   // Vertical half offered.
    HOLDV,  // Vertical half executing.
    HORZ,   // Horizontal half offered.
    HOLDH   // Horizontal half executing.
  } tour_state_e;

endpackage
